// ==== design/mem_op_pkg.sv ====
// Memory opcode definitions
package mem_op_pkg;

    // ----------------------------------------
    // Opcode encoding
    // ----------------------------------------

    // Bit 2 set selects zero extension
    // Bits 1..0 carry the access size
    typedef enum logic [2:0] {
        MEM_LB  = 3'b000,
        MEM_LH  = 3'b001,
        MEM_LW  = 3'b010,
        MEM_LBU = 3'b100,
        MEM_LHU = 3'b101
    } mem_op_e;

    // Stores share the size field and ignore bit 2
    localparam mem_op_e MEM_SB = MEM_LB;
    localparam mem_op_e MEM_SH = MEM_LH;
    localparam mem_op_e MEM_SW = MEM_LW;

    // Access size taken from the low opcode bits
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic mem_size_e op_size(input mem_op_e op);
        return mem_size_e'(op[1:0]);
    endfunction

    // High when the load fills upper bits with zeros
    function automatic logic op_is_unsigned(input mem_op_e op);
        return op[2];
    endfunction

endpackage

// ==== design/dbus_pkg.sv ====
// Data bus constants
package dbus_pkg;

    // ----------------------------------------
    // Word geometry
    // ----------------------------------------

    // Data and address word width
    localparam int DATA_WIDTH = 32;

    // Width of one byte lane
    localparam int BYTE_WIDTH = 8;

    // Width of one halfword
    localparam int HALF_WIDTH = 16;

    // ----------------------------------------
    // Byte lanes
    // ----------------------------------------

    // One enable per byte of the word
    localparam int BYTE_LANES = DATA_WIDTH / BYTE_WIDTH;

    // Address bits selecting a byte inside a word
    localparam int LANE_BITS = 2;

    // Halfwords per word, used when copying store data
    localparam int HALF_LANES = DATA_WIDTH / HALF_WIDTH;

endpackage

// ==== design/lsu_request.sv ====
// Load store request formatter
module lsu_request
    import mem_op_pkg::*;
    import dbus_pkg::*;
(
    // Access from the core
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  mem_op_e               mem_op,
    input  logic [DATA_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] writedata,
    // Request to the data memory
    output logic                  bus_read,
    output logic                  bus_write,
    output logic [DATA_WIDTH-1:0] bus_word_addr,
    output logic [BYTE_LANES-1:0] bus_byte_en,
    output logic [DATA_WIDTH-1:0] bus_writedata,
    // Load tracking toward the aligner
    output logic                  load_accept,
    // Exceptions
    output logic                  load_misaligned,
    output logic                  store_misaligned
);

    mem_size_e                size;
    logic [LANE_BITS-1:0]     byte_offset;
    logic                     addr_misaligned;

    assign size        = op_size(mem_op);
    assign byte_offset = address[LANE_BITS-1:0];

    // ----------------------------------------
    // Alignment check
    // ----------------------------------------

    always_comb begin
        case (size)
            // Word needs both low bits clear
            SIZE_WORD: addr_misaligned = (byte_offset != '0);
            // Halfword only needs bit 0 clear
            SIZE_HALF: addr_misaligned = byte_offset[0];
            // Bytes can sit anywhere
            default:   addr_misaligned = 1'b0;
        endcase
    end

    assign load_misaligned  = mem_read & addr_misaligned;
    assign store_misaligned = mem_write & addr_misaligned;

    // ----------------------------------------
    // Bus strobes and address
    // ----------------------------------------

    // Misaligned access never reaches memory
    assign bus_read  = mem_read & ~addr_misaligned;
    assign bus_write = mem_write & ~addr_misaligned;

    // Same condition marks a load the aligner must finish
    assign load_accept = bus_read;

    // Word-aligned address, low bits forced to zero
    assign bus_word_addr = {address[DATA_WIDTH-1:LANE_BITS], {LANE_BITS{1'b0}}};

    // ----------------------------------------
    // Byte enables
    // ----------------------------------------

    always_comb begin
        case (size)
            SIZE_WORD: bus_byte_en = {BYTE_LANES{1'b1}};
            // Upper or lower half by address bit 1
            SIZE_HALF: bus_byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
            // Single lane for a byte
            default:   bus_byte_en = BYTE_LANES'(1) << byte_offset;
        endcase
    end

    // ----------------------------------------
    // Store data replication
    // ----------------------------------------

    // Copy the store data into every lane
    // Memory picks the right lane through the enables
    always_comb begin
        case (size)
            SIZE_WORD: bus_writedata = writedata;
            SIZE_HALF: bus_writedata = {HALF_LANES{writedata[HALF_WIDTH-1:0]}};
            default:   bus_writedata = {BYTE_LANES{writedata[BYTE_WIDTH-1:0]}};
        endcase
    end

endmodule

// ==== design/lsu_load_align.sv ====
// Load data aligner
module lsu_load_align
    import mem_op_pkg::*;
    import dbus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Issue side
    input  logic                  load_accept,
    input  mem_op_e               mem_op,
    input  logic [LANE_BITS-1:0]  lane_offset,
    // Return side from memory
    input  logic [DATA_WIDTH-1:0] bus_readdata,
    // Result to the core
    output logic [DATA_WIDTH-1:0] readdata,
    output logic                  readdatavalid
);

    // Load context held for the return cycle
    mem_op_e                  op_q;
    logic [LANE_BITS-1:0]     offset_q;
    logic                     pending;

    // Lane picks from the returned word
    logic [HALF_WIDTH-1:0]    half_sel;
    logic [BYTE_WIDTH-1:0]    byte_sel;
    logic                     sign_fill;

    // ----------------------------------------
    // Issue cycle capture
    // ----------------------------------------

    // One result per accepted load, one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= load_accept;
        end
    end

    // Opcode and offset only matter while pending
    always_ff @(posedge clk) begin
        if (load_accept) begin
            op_q     <= mem_op;
            offset_q <= lane_offset;
        end
    end

    assign readdatavalid = pending;

    // ----------------------------------------
    // Return cycle alignment
    // ----------------------------------------

    // Half chosen by the upper offset bit
    assign half_sel = offset_q[LANE_BITS-1] ? bus_readdata[DATA_WIDTH-1:HALF_WIDTH]
                                            : bus_readdata[HALF_WIDTH-1:0];

    // Byte chosen by the full offset
    assign byte_sel = bus_readdata[offset_q*BYTE_WIDTH +: BYTE_WIDTH];

    always_comb begin
        sign_fill = 1'b0;
        case (op_size(op_q))
            SIZE_WORD: begin
                readdata = bus_readdata;
            end
            SIZE_HALF: begin
                // LH copies bit 15 of the half, LHU fills zeros
                sign_fill = ~op_is_unsigned(op_q) & half_sel[HALF_WIDTH-1];
                readdata  = {{(DATA_WIDTH-HALF_WIDTH){sign_fill}}, half_sel};
            end
            default: begin
                // LB copies bit 7 of the byte, LBU fills zeros
                sign_fill = ~op_is_unsigned(op_q) & byte_sel[BYTE_WIDTH-1];
                readdata  = {{(DATA_WIDTH-BYTE_WIDTH){sign_fill}}, byte_sel};
            end
        endcase
    end

endmodule

// ==== design/data_ram.sv ====
// Byte-enabled data memory
module data_ram
    import dbus_pkg::*;
#(
    // Word address width, sets the depth
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                  clk,
    // Request side
    input  logic                  read,
    input  logic                  write,
    input  logic [DATA_WIDTH-1:0] word_addr,
    input  logic [BYTE_LANES-1:0] byte_en,
    input  logic [DATA_WIDTH-1:0] writedata,
    // Registered read port
    output logic [DATA_WIDTH-1:0] readdata
);

    localparam int DEPTH = 1 << MEM_ADDR_BITS;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Word array, contents survive reset
    logic [DATA_WIDTH-1:0]    mem [DEPTH];

    // Word index inside the array
    logic [MEM_ADDR_BITS-1:0] index;

    // Lane bits skipped, bits above the depth dropped
    // so the byte address space wraps
    assign index = word_addr[MEM_ADDR_BITS+LANE_BITS-1:LANE_BITS];

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    // Only enabled lanes change
    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (byte_en[lane]) begin
                    mem[index][lane*BYTE_WIDTH +: BYTE_WIDTH] <=
                        writedata[lane*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // One cycle latency
    // Output holds until the next read
    always_ff @(posedge clk) begin
        if (read) begin
            readdata <= mem[index];
        end
    end

endmodule

// ==== design/lsu_top.sv ====
// Load store unit with data memory
module lsu_top
    import mem_op_pkg::*;
    import dbus_pkg::*;
#(
    // Word address width of the data memory
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    // Access strobes, never both high
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  mem_op_e               mem_op,
    input  logic [DATA_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] writedata,
    // Load result, one cycle after the strobe
    output logic [DATA_WIDTH-1:0] readdata,
    output logic                  readdatavalid,
    // Exceptions in the strobe cycle
    output logic                  load_misaligned,
    output logic                  store_misaligned
);

    // ----------------------------------------
    // Internal bus
    // ----------------------------------------

    logic                  bus_read;
    logic                  bus_write;
    logic [DATA_WIDTH-1:0] bus_word_addr;
    logic [BYTE_LANES-1:0] bus_byte_en;
    logic [DATA_WIDTH-1:0] bus_writedata;
    logic [DATA_WIDTH-1:0] bus_readdata;

    // Aligned load heading to the return side
    logic                  load_accept;

    // ----------------------------------------
    // Issue side
    // ----------------------------------------

    lsu_request u_request (
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_op           (mem_op),
        .address          (address),
        .writedata        (writedata),
        .bus_read         (bus_read),
        .bus_write        (bus_write),
        .bus_word_addr    (bus_word_addr),
        .bus_byte_en      (bus_byte_en),
        .bus_writedata    (bus_writedata),
        .load_accept      (load_accept),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    // ----------------------------------------
    // Data memory
    // ----------------------------------------

    // Stands in for the hidden memory stage
    data_ram #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_data_ram (
        .clk       (clk),
        .read      (bus_read),
        .write     (bus_write),
        .word_addr (bus_word_addr),
        .byte_en   (bus_byte_en),
        .writedata (bus_writedata),
        .readdata  (bus_readdata)
    );

    // ----------------------------------------
    // Return side
    // ----------------------------------------

    // Offset taken straight from the byte address
    lsu_load_align u_load_align (
        .clk           (clk),
        .rst           (rst),
        .load_accept   (load_accept),
        .mem_op        (mem_op),
        .lane_offset   (address[LANE_BITS-1:0]),
        .bus_readdata  (bus_readdata),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

endmodule

// ==== tests/tb_lsu_top.sv ====
// Load store unit testbench
module tb_lsu_top
    import mem_op_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // Run limits
    // ----------------------------------------

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int MEM_WORDS     = 64;
    // One cycle per step, budget per phase
    localparam int FILL_OPS      = MEM_WORDS + 1;
    localparam int DIRECTED_OPS  = 80;
    localparam int RANDOM_OPS    = 200;
    localparam int TOTAL_OPS     = FILL_OPS + DIRECTED_OPS + RANDOM_OPS + 1;
    localparam int MARGIN_CYCLES = 100;
    // Taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk;
    logic        rst;
    logic        mem_read;
    logic        mem_write;
    mem_op_e     mem_op;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic        readdatavalid;
    logic        load_misaligned;
    logic        store_misaligned;

    // Byte model of the 64-word memory
    logic [7:0]  model_mem [256];
    logic [31:0] lfsr_state;

    // Result due at the next falling edge
    logic        exp_valid;
    logic [31:0] exp_data;

    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    lsu_top #(
        .MEM_ADDR_BITS (6)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_op           (mem_op),
        .address          (address),
        .writedata        (writedata),
        .readdata         (readdata),
        .readdatavalid    (readdatavalid),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a run that stalls
    initial begin
        #((TOTAL_OPS * 4 + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (out_bit ? LFSR_TAPS : 32'h0);
            value      = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // Word needs offset 0, half needs an even offset
    function automatic logic is_misaligned(input mem_op_e op, input logic [31:0] addr);
        case (op[1:0])
            2'b10:   return addr[1:0] != 2'b00;
            2'b01:   return addr[0];
            default: return 1'b0;
        endcase
    endfunction

    // Little endian, bit 2 of the opcode picks zero fill
    function automatic logic [31:0] model_load(input mem_op_e op, input logic [31:0] addr);
        logic [7:0]  a;
        logic [15:0] half;
        logic [7:0]  byte_val;
        a        = addr[7:0];
        half     = {model_mem[8'(a + 1)], model_mem[a]};
        byte_val = model_mem[a];
        case (op[1:0])
            2'b10:   return {model_mem[8'(a + 3)], model_mem[8'(a + 2)], half};
            2'b01:   return op[2] ? {16'h0, half} : {{16{half[15]}}, half};
            default: return op[2] ? {24'h0, byte_val} : {{24{byte_val[7]}}, byte_val};
        endcase
    endfunction

    function automatic void model_store(input mem_op_e op, input logic [31:0] addr,
                                        input logic [31:0] data);
        int nbytes;
        nbytes = (op[1:0] == 2'b10) ? 4 : (op[1:0] == 2'b01) ? 2 : 1;
        for (int i = 0; i < nbytes; i++) begin
            model_mem[8'(addr[7:0] + i)] = data[8*i +: 8];
        end
    endfunction

    // ----------------------------------------
    // Checking and reporting
    // ----------------------------------------

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic plain_error(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
        total_errors++;
    endtask

    // Registered outputs, stable at the falling edge
    task automatic check_return();
        if (exp_valid && readdatavalid !== 1'b1) begin
            plain_error("no readdatavalid within 1 cycle of a load");
        end else if (!exp_valid && readdatavalid !== 1'b0) begin
            plain_error("unexpected readdatavalid");
        end else if (exp_valid && readdata !== exp_data) begin
            value_error("readdata", exp_data, readdata);
        end
    endtask

    // One cycle: collect last result, drive, check flags
    task automatic step(input logic rd, input logic wr, input mem_op_e op,
                        input logic [31:0] addr, input logic [31:0] data);
        logic mis;
        @(negedge clk);
        check_return();
        mem_read  = rd;
        mem_write = wr;
        mem_op    = op;
        address   = addr;
        writedata = data;
        #1;
        mis = is_misaligned(op, addr);
        if (load_misaligned !== (rd & mis)) begin
            value_error("load_misaligned", 32'(rd & mis), 32'(load_misaligned));
        end
        if (store_misaligned !== (wr & mis)) begin
            value_error("store_misaligned", 32'(wr & mis), 32'(store_misaligned));
        end
        exp_valid = rd & ~mis;
        if (rd && !mis) begin
            exp_data = model_load(op, addr);
        end
        if (wr && !mis) begin
            model_store(op, addr, data);
        end
    endtask

    task automatic idle();
        step(1'b0, 1'b0, MEM_LW, 32'h0, 32'h0);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%-18s %s, %0d errors", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic test_word_round_trip();
        start_test("word_round_trip");
        if (readdatavalid !== 1'b0) begin
            plain_error("readdatavalid not low after reset");
        end
        step(1'b0, 1'b1, MEM_SW, 32'h0000_0048, 32'hcafe_f00d);
        step(1'b1, 1'b0, MEM_LW, 32'h0000_0048, 32'h0);
        idle();
        // Pulse must drop again
        idle();
        end_test();
    endtask

    // Contents survive reset, so give every word a known value
    task automatic fill_memory();
        logic [31:0] addr;
        start_test("memory_fill");
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr = 32'(i * 4);
            step(1'b0, 1'b1, MEM_SW, addr, (addr ^ 32'h5a5a_0000) * 32'h9e37_79b9);
        end
        idle();
        end_test();
    endtask

    task automatic test_byte_lanes();
        logic [31:0] pattern;
        logic [31:0] addr;
        start_test("byte_lanes");
        pattern = 32'h0cf0_7a85;
        for (int off = 0; off < 4; off++) begin
            // 0x100 wraps onto word 0
            addr = 32'h100 + off;
            step(1'b0, 1'b1, MEM_SB, addr, {24'hd1e2f3, pattern[8*off +: 8]});
            step(1'b1, 1'b0, MEM_LW, {addr[31:2], 2'b00}, 32'h0);
            step(1'b1, 1'b0, MEM_LB, addr, 32'h0);
            step(1'b1, 1'b0, MEM_LBU, addr, 32'h0);
        end
        idle();
        end_test();
    endtask

    task automatic test_halfword_lanes();
        logic [31:0] base;
        logic [15:0] half;
        start_test("halfword_lanes");
        base = 32'h0000_0064;
        step(1'b0, 1'b1, MEM_SW, base, 32'h1234_5678);
        for (int off = 0; off < 4; off += 2) begin
            half = (off == 0) ? 16'h8a5c : 16'h7e01;
            step(1'b0, 1'b1, MEM_SH, base + off, {16'hbeef, half});
            step(1'b1, 1'b0, MEM_LW, base, 32'h0);
            step(1'b1, 1'b0, MEM_LH, base + off, 32'h0);
            step(1'b1, 1'b0, MEM_LHU, base + off, 32'h0);
        end
        idle();
        end_test();
    endtask

    task automatic test_misalignment();
        logic [31:0] base;
        start_test("misalignment");
        base = 32'h0000_0080;
        step(1'b0, 1'b1, MEM_SW, base, 32'h0bad_c0de);
        for (int off = 1; off < 4; off++) begin
            step(1'b1, 1'b0, MEM_LW, base + off, 32'h0);
        end
        step(1'b1, 1'b0, MEM_LH, base + 1, 32'h0);
        step(1'b1, 1'b0, MEM_LHU, base + 3, 32'h0);
        step(1'b0, 1'b1, MEM_SH, base + 1, 32'h0000_ffff);
        step(1'b0, 1'b1, MEM_SH, base + 3, 32'h0000_1111);
        step(1'b0, 1'b1, MEM_SW, base + 2, 32'h2222_3333);
        // Word must still hold the first store
        step(1'b1, 1'b0, MEM_LW, base, 32'h0);
        idle();
        end_test();
    endtask

    task automatic test_back_to_back();
        start_test("back_to_back");
        step(1'b1, 1'b0, MEM_LW, 32'h0000_0010, 32'h0);
        step(1'b1, 1'b0, MEM_LB, 32'h0000_0021, 32'h0);
        step(1'b1, 1'b0, MEM_LHU, 32'h0000_0022, 32'h0);
        step(1'b1, 1'b0, MEM_LBU, 32'h0000_0013, 32'h0);
        step(1'b1, 1'b0, MEM_LH, 32'h0000_0030, 32'h0);
        // Top word reached through a wrapped address
        step(1'b1, 1'b0, MEM_LW, 32'hffff_fffc, 32'h0);
        // Load right behind a store sees the new byte
        step(1'b0, 1'b1, MEM_SB, 32'h0000_0041, 32'h0000_00e7);
        step(1'b1, 1'b0, MEM_LBU, 32'h0000_0041, 32'h0);
        idle();
        end_test();
    endtask

    task automatic test_random_mix();
        logic        is_load;
        logic [1:0]  size;
        logic        uns;
        logic [31:0] addr;
        logic [31:0] data;
        start_test("random_mix");
        for (int i = 0; i < RANDOM_OPS; i++) begin
            is_load = lfsr_bits(1) != 0;
            size    = 2'(lfsr_bits(2));
            // No opcode for size 3, fold it onto word
            if (size == 2'b11) begin
                size = 2'b10;
            end
            uns  = (size == 2'b10) ? 1'b0 : (lfsr_bits(1) != 0);
            addr = lfsr_bits(32);
            data = lfsr_bits(32);
            step(is_load, ~is_load, mem_op_e'({uns, size}), addr, data);
        end
        idle();
        end_test();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rst          = 1'b1;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_op       = MEM_LW;
        address      = '0;
        writedata    = '0;
        exp_valid    = 1'b0;
        exp_data     = '0;
        lfsr_state   = 32'hea83;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_word_round_trip();
        fill_memory();
        test_byte_lanes();
        test_halfword_lanes();
        test_misalignment();
        test_back_to_back();
        test_random_mix();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/mem_op_pkg.sv
design/dbus_pkg.sv
design/lsu_request.sv
design/lsu_load_align.sv
design/data_ram.sv
design/lsu_top.sv
tests/tb_lsu_top.sv
